// ==== div_cfg.svh ====
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// ******************************
// divider geometry
// ******************************
`define DIV_N_W         16  // dividend width
`define DIV_D_W         8   // divisor, quotient and remainder width
`define DIV_APPROX_ROWS 4   // quotient rows 0 .. n-1 use approximate cells

// statistics
`define DIV_STAT_W      24

`endif

// ==== div_pkg.sv ====
`include "div_cfg.svh"

package div_pkg;

  // ******************************
  // operand and result bundles
  // ******************************

  typedef struct packed {
    logic [`DIV_N_W-1:0] dividend;
    logic [`DIV_D_W-1:0] divisor;
  } div_operand_t;

  typedef struct packed {
    logic [`DIV_D_W-1:0] quotient;
    logic [`DIV_D_W-1:0] remainder;  // meaningful only without overflow
  } div_result_t;

endpackage

// ==== err_pkg.sv ====
`include "div_cfg.svh"

package err_pkg;

  import div_pkg::*;

  typedef struct packed {
    div_result_t         exact;
    div_result_t         approx;
    logic [`DIV_D_W-1:0] q_err_dist;  // absolute quotient difference
    logic [`DIV_D_W-1:0] r_err_dist;  // absolute remainder difference
    logic                mismatch;
    logic                invalid;     // marks a zero divisor or overflow that stats never count
  } div_cmp_t;

  typedef struct packed {
    logic [`DIV_STAT_W-1:0] n_ops;
    logic [`DIV_STAT_W-1:0] n_mismatch;
    logic [`DIV_STAT_W-1:0] q_err_sum;
    logic [`DIV_STAT_W-1:0] q_err_max;
  } err_stats_t;

endpackage

// ==== div_stage_reg.sv ====
module div_stage_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  // strobe follows the input every cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out <= '0;
    end else if (valid_in) begin
      data_out <= data_in;  // holds the last operation between strobes
    end
  end

endmodule

// ==== div_array_exact.sv ====
`include "div_cfg.svh"

module div_array_exact
  import div_pkg::*;
(
  input  div_operand_t operands,
  output div_result_t  res
);

  localparam int N_W = `DIV_N_W;
  localparam int D_W = `DIV_D_W;

  // ******************************
  // exact subtractor cell
  // ******************************

  // returns {borrow out, difference}
  function automatic logic [1:0] sub_cell(input logic x, input logic y, input logic bin);
    logic diff;
    logic bout;
    diff = x ^ y ^ bin;
    bout = (~x & y) | (~(x ^ y) & bin);
    return {bout, diff};
  endfunction

  // ******************************
  // restoring rows, msb first
  // ******************************

  always_comb begin : p_rows
    logic [D_W-1:0] win;
    logic [D_W-1:0] diff;
    logic [D_W-1:0] rem;
    logic [D_W-1:0] q;
    logic           hi;
    logic           brw;
    rem = '0;
    q   = '0;
    for (int i = D_W - 1; i >= 0; i--) begin
      if (i == D_W - 1) begin
        win = operands.dividend[N_W-2 -: D_W];  // dividend bits 14 down to 7
        hi  = operands.dividend[N_W-1];
      end else begin
        win = {rem[D_W-2:0], operands.dividend[i]};  // shift in next dividend bit
        hi  = rem[D_W-1];
      end
      brw = 1'b0;
      for (int k = 0; k < D_W; k++) begin
        {brw, diff[k]} = sub_cell(win[k], operands.divisor[k], brw);
      end
      // a set bit above the window always fits the divisor
      q[i] = hi | ~brw;
      rem  = q[i] ? diff : win;  // restore when the subtraction failed
    end
    res.quotient  = q;
    res.remainder = rem;
  end

endmodule

// ==== div_array_approx.sv ====
`include "div_cfg.svh"

module div_array_approx
  import div_pkg::*;
(
  input  div_operand_t operands,
  output div_result_t  res
);

  localparam int N_W         = `DIV_N_W;
  localparam int D_W         = `DIV_D_W;
  localparam int APPROX_ROWS = `DIV_APPROX_ROWS;

  // ******************************
  // cells
  // ******************************

  // exact cell, returns {borrow out, difference}
  function automatic logic [1:0] sub_cell(input logic x, input logic y, input logic bin);
    logic diff;
    logic bout;
    diff = x ^ y ^ bin;
    bout = (~x & y) | (~(x ^ y) & bin);
    return {bout, diff};
  endfunction

  // approximate cell
  // the difference is the minuend bit and the borrow is its inverse,
  // so subtrahend and borrow in drop out of the row entirely
  function automatic logic [1:0] approx_cell(input logic x);
    logic diff;
    logic bout;
    diff = x;
    bout = ~x;
    return {bout, diff};
  endfunction

  // ******************************
  // restoring rows, msb first
  // ******************************

  always_comb begin : p_rows
    logic [D_W-1:0] win;
    logic [D_W-1:0] diff;
    logic [D_W-1:0] rem;
    logic [D_W-1:0] q;
    logic           hi;
    logic           brw;
    rem = '0;
    q   = '0;
    for (int i = D_W - 1; i >= 0; i--) begin
      if (i == D_W - 1) begin
        win = operands.dividend[N_W-2 -: D_W];
        hi  = operands.dividend[N_W-1];
      end else begin
        win = {rem[D_W-2:0], operands.dividend[i]};
        hi  = rem[D_W-1];
      end
      brw = 1'b0;
      for (int k = 0; k < D_W; k++) begin
        if (i < APPROX_ROWS) begin
          {brw, diff[k]} = approx_cell(win[k]);
        end else begin
          {brw, diff[k]} = sub_cell(win[k], operands.divisor[k], brw);
        end
      end
      // in approximate rows this reduces to hi | win msb
      q[i] = hi | ~brw;
      rem  = q[i] ? diff : win;
    end
    res.quotient  = q;
    res.remainder = rem;
  end

endmodule

// ==== div_err_meas.sv ====
`include "div_cfg.svh"

module div_err_meas
  import div_pkg::*;
  import err_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         clr,
  input  logic         valid,
  input  div_operand_t operands,
  input  div_result_t  exact,
  input  div_result_t  approx,
  output div_cmp_t     cmp,
  output err_stats_t   stats
);

  localparam int N_W = `DIV_N_W;
  localparam int D_W = `DIV_D_W;
  localparam int S_W = `DIV_STAT_W;
  localparam logic [S_W-1:0] STAT_MAX = '1;

  function automatic logic [D_W-1:0] abs_diff(input logic [D_W-1:0] a, input logic [D_W-1:0] b);
    return (a > b) ? a - b : b - a;
  endfunction

  logic           count_en;
  logic [S_W-1:0] q_dist_ext;
  logic [S_W:0]   q_sum_next;

  // ******************************
  // per-operation record
  // ******************************

  always_comb begin
    cmp.exact      = exact;
    cmp.approx     = approx;
    cmp.q_err_dist = abs_diff(exact.quotient, approx.quotient);
    cmp.r_err_dist = abs_diff(exact.remainder, approx.remainder);
    cmp.mismatch   = (exact != approx);
    cmp.invalid    = (operands.divisor == '0) ||
                     (operands.dividend[N_W-1 -: D_W] >= operands.divisor);  // overflow
  end

  // ******************************
  // running statistics
  // ******************************

  assign count_en   = valid && !cmp.invalid;
  assign q_dist_ext = S_W'(cmp.q_err_dist);
  assign q_sum_next = {1'b0, stats.q_err_sum} + {1'b0, q_dist_ext};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stats <= '0;
    end else if (clr) begin
      stats <= '0;  // wins over a coinciding operation
    end else if (count_en) begin
      if (stats.n_ops != STAT_MAX) begin
        stats.n_ops <= stats.n_ops + 1'b1;
      end
      if (cmp.mismatch && (stats.n_mismatch != STAT_MAX)) begin
        stats.n_mismatch <= stats.n_mismatch + 1'b1;
      end
      stats.q_err_sum <= q_sum_next[S_W] ? STAT_MAX : q_sum_next[S_W-1:0];
      if (q_dist_ext > stats.q_err_max) begin
        stats.q_err_max <= q_dist_ext;
      end
    end
  end

endmodule

// ==== div_eval_top.sv ====
module div_eval_top
  import div_pkg::*;
  import err_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         in_valid,
  input  div_operand_t operands,
  input  logic         clr,
  output logic         out_valid,
  output div_cmp_t     result,
  output err_stats_t   stats
);

  logic         op_valid;
  div_operand_t op_reg;
  div_result_t  exact_res;
  div_result_t  approx_res;
  div_cmp_t     cmp;

  // ******************************
  // input stage
  // ******************************

  div_stage_reg #(
    .payload_t (div_operand_t)
  ) u_in_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (in_valid),
    .data_in   (operands),
    .valid_out (op_valid),
    .data_out  (op_reg)
  );

  // both arrays see the same registered operands
  div_array_exact u_exact (
    .operands (op_reg),
    .res      (exact_res)
  );

  div_array_approx u_approx (
    .operands (op_reg),
    .res      (approx_res)
  );

  div_err_meas u_meas (
    .clk      (clk),
    .arst_n   (arst_n),
    .clr      (clr),
    .valid    (op_valid),
    .operands (op_reg),
    .exact    (exact_res),
    .approx   (approx_res),
    .cmp      (cmp),
    .stats    (stats)      // updates on the edge that raises out_valid
  );

  // ******************************
  // output stage
  // ******************************

  div_stage_reg #(
    .payload_t (div_cmp_t)
  ) u_out_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (op_valid),
    .data_in   (cmp),
    .valid_out (out_valid),
    .data_out  (result)
  );

endmodule

// ==== div_eval_chk.sv ====
`include "div_cfg.svh"

module div_eval_chk
  import div_pkg::*;
  import err_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         in_valid,
  input  div_operand_t operands,
  input  logic         clr,
  input  logic         out_valid,
  input  div_cmp_t     result,
  input  err_stats_t   stats,
  output int           err_count,
  output int           pending
);

  localparam int D_W = `DIV_D_W;
  localparam int S_W = `DIV_STAT_W;
  localparam int A_R = `DIV_APPROX_ROWS;
  localparam logic [S_W-1:0] STAT_MAX = '1;

  div_operand_t op_q[$];       // operations waiting for out_valid
  logic         stage_valid;   // operation now in the measurement stage
  div_operand_t stage_op;
  err_stats_t   model;

  // ******************************
  // reference functions
  // ******************************

  function automatic logic is_invalid(input div_operand_t op);
    return (op.divisor == 0) || ((op.dividend >> D_W) >= op.divisor);
  endfunction

  function automatic div_result_t exact_div(input div_operand_t op);
    div_result_t r;
    r.quotient  = D_W'(op.dividend / op.divisor);
    r.remainder = D_W'(op.dividend % op.divisor);
    return r;
  endfunction

  // upper rows divide exactly, approximate rows only look at the top two remainder bits
  function automatic div_result_t approx_div(input div_operand_t op);
    div_result_t    r;
    logic [15:0]    upper;
    logic [D_W-1:0] q;
    logic [D_W-1:0] rem;
    upper = op.dividend >> A_R;
    q     = D_W'((upper / op.divisor) << A_R);
    rem   = D_W'(upper % op.divisor);
    for (int i = A_R - 1; i >= 0; i--) begin
      q[i] = rem[D_W-1] | rem[D_W-2];
      rem  = {rem[D_W-2:0], op.dividend[i]};  // no subtraction ever lands
    end
    r.quotient  = q;
    r.remainder = rem;
    return r;
  endfunction

  function automatic logic [D_W-1:0] err_dist(input int a, input int b);
    return D_W'((a > b) ? a - b : b - a);
  endfunction

  function automatic div_cmp_t expect_record(input div_operand_t op);
    div_cmp_t c;
    c = '0;
    c.invalid = is_invalid(op);
    if (!c.invalid) begin
      c.exact      = exact_div(op);
      c.approx     = approx_div(op);
      c.q_err_dist = err_dist(int'(c.exact.quotient), int'(c.approx.quotient));
      c.r_err_dist = err_dist(int'(c.exact.remainder), int'(c.approx.remainder));
      c.mismatch   = (c.q_err_dist != 0) || (c.r_err_dist != 0);
    end
    return c;
  endfunction

  function automatic err_stats_t next_stats(input err_stats_t s, input div_cmp_t c);
    err_stats_t n;
    longint     sum;
    n = s;
    if (s.n_ops != STAT_MAX) n.n_ops = s.n_ops + 1;
    if (c.mismatch && (s.n_mismatch != STAT_MAX)) n.n_mismatch = s.n_mismatch + 1;
    sum = longint'(s.q_err_sum) + longint'(c.q_err_dist);
    n.q_err_sum = (sum > longint'(STAT_MAX)) ? STAT_MAX : S_W'(sum);  // saturates
    if (S_W'(c.q_err_dist) > s.q_err_max) n.q_err_max = S_W'(c.q_err_dist);
    return n;
  endfunction

  // ******************************
  // comparison
  // ******************************

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
      err_count++;
    end
  endtask

  task automatic compare_record(input div_cmp_t exp, input div_cmp_t got);
    check_field("result.invalid", 32'(exp.invalid), 32'(got.invalid));
    if (!exp.invalid) begin  // other fields carry no meaning for an invalid operation
      check_field("result.exact.quotient", 32'(exp.exact.quotient), 32'(got.exact.quotient));
      check_field("result.exact.remainder", 32'(exp.exact.remainder), 32'(got.exact.remainder));
      check_field("result.approx.quotient", 32'(exp.approx.quotient), 32'(got.approx.quotient));
      check_field("result.approx.remainder", 32'(exp.approx.remainder),
                  32'(got.approx.remainder));
      check_field("result.q_err_dist", 32'(exp.q_err_dist), 32'(got.q_err_dist));
      check_field("result.r_err_dist", 32'(exp.r_err_dist), 32'(got.r_err_dist));
      check_field("result.mismatch", 32'(exp.mismatch), 32'(got.mismatch));
    end
  endtask

  task automatic compare_stats(input err_stats_t exp, input err_stats_t got);
    check_field("stats.n_ops", 32'(exp.n_ops), 32'(got.n_ops));
    check_field("stats.n_mismatch", 32'(exp.n_mismatch), 32'(got.n_mismatch));
    check_field("stats.q_err_sum", 32'(exp.q_err_sum), 32'(got.q_err_sum));
    check_field("stats.q_err_max", 32'(exp.q_err_max), 32'(got.q_err_max));
  endtask

  initial begin
    err_count = 0;
    pending   = 0;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q.delete();
      stage_valid = 1'b0;
      stage_op    = '0;
      model       = '0;
    end else begin
      compare_stats(model, stats);  // stats now hold every edge before this one
      if (clr) begin
        model = '0;
      end else if (stage_valid && !is_invalid(stage_op)) begin
        model = next_stats(model, expect_record(stage_op));
      end
      stage_valid = in_valid;
      stage_op    = operands;
      if (out_valid) begin
        if (op_q.size() == 0) begin
          $display("out_valid arrived at t=%0t with no operation outstanding", $time);
          err_count++;
        end else begin
          compare_record(expect_record(op_q.pop_front()), result);
        end
      end
      if (in_valid) op_q.push_back(operands);
    end
    pending = op_q.size();
  end

endmodule

// ==== div_eval_props.sv ====
module div_eval_props
  import err_pkg::*;
(
  input logic       clk,
  input logic       arst_n,
  input logic       in_valid,
  input logic       clr,
  input logic       out_valid,
  input err_stats_t stats
);

  // ******************************
  // latency and reset
  // ******************************

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid, 2))
    else $error("out_valid is not in_valid delayed by two cycles");

  a_reset_low: assert property (@(posedge clk)
    !arst_n |-> !out_valid)
    else $error("out_valid is high while reset is asserted");

  // ******************************
  // statistics clear
  // ******************************

  a_clr_zero: assert property (@(posedge clk) disable iff (!arst_n)
    clr |=> (stats == '0))
    else $error("stats are not zero in the cycle after clr");

endmodule

// ==== div_eval_tb.sv ====
module div_eval_tb
  import div_pkg::*;
  import err_pkg::*;
();

  logic         clk;
  logic         arst_n;
  logic         in_valid;
  div_operand_t operands;
  logic         clr;
  logic         out_valid;
  div_cmp_t     result;
  err_stats_t   stats;
  int           chk_errors;
  int           pending;
  int           tb_errors;
  int           err_base;
  int           tests_passed;
  int           tests_failed;
  logic [15:0]  lfsr_state;

  div_eval_top u_div_eval_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .operands  (operands),
    .clr       (clr),
    .out_valid (out_valid),
    .result    (result),
    .stats     (stats)
  );

  div_eval_chk u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .operands  (operands),
    .clr       (clr),
    .out_valid (out_valid),
    .result    (result),
    .stats     (stats),
    .err_count (chk_errors),
    .pending   (pending)
  );

  bind div_eval_top div_eval_props u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .clr       (clr),
    .out_valid (out_valid),
    .stats     (stats)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ******************************
  // stimulus helpers
  // ******************************

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val        = {val[14:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // upper dividend byte is kept below the divisor
  task automatic random_valid_op(output div_operand_t op);
    logic [15:0] d;
    logic [15:0] hi;
    logic [15:0] lo;
    take_bits(8, d);
    if (d[7:0] == 8'h00) d = 16'h0001;
    take_bits(8, hi);
    take_bits(8, lo);
    op.divisor  = d[7:0];
    op.dividend = {8'(hi % d), lo[7:0]};
  endtask

  task automatic drive_cycle(input logic v, input div_operand_t op, input logic c);
    @(posedge clk);
    #1;
    in_valid = v;
    operands = op;
    clr      = c;
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    drive_cycle(1'b0, '0, 1'b0);
    while ((pending != 0) && (cycles < 20)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (pending != 0) begin
      $display("timeout after %0d cycles, %0d operation(s) never got out_valid", cycles, pending);
      tb_errors++;
    end
  endtask

  task automatic expect_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
      tb_errors++;
    end
  endtask

  task automatic start_test();
    err_base = chk_errors + tb_errors;
  endtask

  task automatic close_test(input string name);
    int n;
    n = chk_errors + tb_errors - err_base;
    if (n == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, n);
    end
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    div_operand_t op;
    logic [31:0]  base;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    operands     = '0;
    clr          = 1'b0;
    tb_errors    = 0;
    err_base     = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr_state   = 16'd12776;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    start_test();
    for (int n = 0; n < 300; n++) begin
      random_valid_op(op);
      drive_cycle(1'b1, op, 1'b0);
      drive_cycle(1'b0, '0, 1'b0);
    end
    wait_results();
    close_test("random valid operands");

    start_test();
    base = 32'(stats.n_mismatch);
    drive_cycle(1'b1, {16'h0005, 8'h01}, 1'b0);  // low quotient nibble is lost
    drive_cycle(1'b1, {16'h00ff, 8'h03}, 1'b0);
    drive_cycle(1'b1, {16'h0033, 8'h02}, 1'b0);
    wait_results();
    expect_value("stats.n_mismatch", base + 3, 32'(stats.n_mismatch));
    base = 32'(stats.n_mismatch);
    drive_cycle(1'b1, {16'h0100, 8'h02}, 1'b0);  // quotient ends in four zeros
    drive_cycle(1'b1, {16'h3c00, 8'h40}, 1'b0);
    wait_results();
    expect_value("stats.n_mismatch", base, 32'(stats.n_mismatch));
    close_test("directed approximate rows");

    start_test();
    base = 32'(stats.n_ops);
    drive_cycle(1'b1, {16'h1234, 8'h00}, 1'b0);
    drive_cycle(1'b1, {16'h8000, 8'h80}, 1'b0);
    drive_cycle(1'b1, {16'hffff, 8'h10}, 1'b0);
    wait_results();
    expect_value("stats.n_ops", base, 32'(stats.n_ops));
    close_test("zero divisor and overflow");

    start_test();
    for (int n = 0; n < 16; n++) begin
      random_valid_op(op);
      drive_cycle(1'b1, op, 1'b0);
    end
    wait_results();
    close_test("back-to-back strobes");

    start_test();
    drive_cycle(1'b0, '0, 1'b1);
    drive_cycle(1'b0, '0, 1'b0);
    expect_value("stats.n_ops", 0, 32'(stats.n_ops));
    expect_value("stats.q_err_sum", 0, 32'(stats.q_err_sum));
    for (int n = 0; n < 5; n++) begin
      random_valid_op(op);
      drive_cycle(1'b1, op, 1'b0);
    end
    wait_results();
    expect_value("stats.n_ops", 5, 32'(stats.n_ops));
    random_valid_op(op);
    drive_cycle(1'b1, op, 1'b0);
    drive_cycle(1'b0, '0, 1'b1);  // meets the operation in the measurement stage
    wait_results();
    expect_value("stats.n_ops", 0, 32'(stats.n_ops));
    close_test("statistics clear");

    start_test();
    random_valid_op(op);
    drive_cycle(1'b1, op, 1'b0);
    random_valid_op(op);
    drive_cycle(1'b1, op, 1'b0);
    drive_cycle(1'b0, '0, 1'b0);
    arst_n = 1'b0;  // first result is on the outputs and the second is one stage behind
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    expect_value("out_valid", 0, 64'(out_valid));
    expect_value("result", 0, 64'(result));
    expect_value("stats.n_ops", 0, 64'(stats.n_ops));
    close_test("reset during traffic");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if ((tests_failed == 0) && (chk_errors == 0) && (tb_errors == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
div_pkg.sv
err_pkg.sv
div_stage_reg.sv
div_array_exact.sv
div_array_approx.sv
div_err_meas.sv
div_eval_top.sv
div_eval_chk.sv
div_eval_props.sv
div_eval_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the divider error testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module div_eval_tb -f all.f -o div_eval_sim

# the log decides the outcome, so a stopped simulation must not end the script here
./obj_dir/div_eval_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^TB PASSED$" sim.log
echo "simulation passed"
